/* logic/sw_pkg.sv */
// scoring constants, size limits and shared types of the smith-waterman engine, imported by all RTL
`default_nettype none

package sw_pkg;

    // job size limits
    localparam int REF_MAX_LEN  = 16;
    localparam int READ_MAX_LEN = 8;
    localparam int SCORE_W      = 10;

    // A=0, C=1, G=2, T=3
    typedef logic [1:0] base_t;

    typedef logic signed [SCORE_W-1:0] score_t;

    // base k sits in bits 2k+1 down to 2k
    typedef logic [2*REF_MAX_LEN-1:0]  ref_seq_t;
    typedef logic [2*READ_MAX_LEN-1:0] read_seq_t;

    // lengths are 1-based, indices 0-based
    typedef logic [$clog2(REF_MAX_LEN):0]    ref_len_t;
    typedef logic [$clog2(READ_MAX_LEN):0]   read_len_t;
    typedef logic [$clog2(REF_MAX_LEN)-1:0]  ref_idx_t;
    typedef logic [$clog2(READ_MAX_LEN)-1:0] read_idx_t;

    // affine gap scoring
    localparam score_t MATCH_SCORE      = 5;
    localparam score_t MISMATCH_PENALTY = 2;
    localparam score_t GAP_OPEN         = 3;
    localparam score_t GAP_EXTEND       = 1;

    // loader fsm encoding
    localparam logic [1:0] LD_IDLE   = 2'd0;
    localparam logic [1:0] LD_STREAM = 2'd1;
    localparam logic [1:0] LD_DRAIN  = 2'd2;
    localparam logic [1:0] LD_WAIT   = 2'd3;

endpackage

`default_nettype wire

/* logic/sw_seq_loader.sv */
// job capture stage, streams the reference into the pe array, waits out the drain and starts the scan
`timescale 1ns/1ps
`default_nettype none

module sw_seq_loader (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_valid,
    input  sw_pkg::ref_seq_t  i_ref_seq,
    input  sw_pkg::read_seq_t i_read_seq,
    input  sw_pkg::ref_len_t  i_ref_len,
    input  sw_pkg::read_len_t i_read_len,
    input  logic              i_scan_busy,
    output logic              o_ready,
    output logic              o_start,
    output logic              o_stream_valid,
    output sw_pkg::base_t     o_stream_base,
    output sw_pkg::read_seq_t o_read_seq,
    output sw_pkg::read_len_t o_read_len,
    output logic              o_scan_start
);
    import sw_pkg::*;

    logic [1:0] state;
    ref_len_t   cnt;
    ref_len_t   ref_len_q;
    ref_seq_t   ref_shift;
    logic       last_base;
    logic       drain_done;

    assign last_base  = (cnt == ref_len_q - ref_len_t'(1));
    assign drain_done = (cnt == ref_len_t'(READ_MAX_LEN - 1));

    assign o_ready        = (state == LD_IDLE);
    assign o_stream_valid = (state == LD_STREAM);
    assign o_stream_base  = ref_shift[1:0];
    // first stream cycle opens the job in every element
    assign o_start        = (state == LD_STREAM) && (cnt == '0);
    assign o_scan_start   = (state == LD_DRAIN) && drain_done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= LD_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                LD_IDLE: begin
                    if (i_valid) begin
                        state <= LD_STREAM;
                    end
                end
                LD_STREAM: begin
                    if (last_base) begin
                        cnt   <= '0;
                        state <= LD_DRAIN;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                // last element trails element 0 by READ_MAX_LEN-1 cycles
                LD_DRAIN: begin
                    if (drain_done) begin
                        cnt   <= '0;
                        state <= LD_WAIT;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                LD_WAIT: begin
                    if (!i_scan_busy) begin
                        state <= LD_IDLE;
                    end
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready && i_valid) begin
            ref_shift  <= i_ref_seq;
            ref_len_q  <= i_ref_len;
            o_read_seq <= i_read_seq;
            o_read_len <= i_read_len;
        end else if (state == LD_STREAM) begin
            // next base into the low bits
            ref_shift <= ref_shift >> 2;
        end
    end

endmodule

`default_nettype wire

/* logic/sw_pe.sv */
// one systolic element of the array, computes one read row with affine gaps and tracks its row best
`timescale 1ns/1ps
`default_nettype none

module sw_pe (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_start,
    input  logic             i_row_en,
    input  logic             i_valid,
    input  sw_pkg::base_t    i_ref_base,
    input  sw_pkg::base_t    i_read_base,
    input  sw_pkg::score_t   i_top_h,
    input  sw_pkg::score_t   i_top_f,
    output logic             o_valid,
    output sw_pkg::base_t    o_ref_base,
    output sw_pkg::score_t   o_h,
    output sw_pkg::score_t   o_f,
    output sw_pkg::score_t   o_row_best,
    output sw_pkg::ref_idx_t o_row_best_col
);
    import sw_pkg::*;

    score_t   e_q;
    score_t   diag_q;
    ref_idx_t col_q;
    score_t   left_h;
    score_t   left_e;
    score_t   diag;
    score_t   cur_best;
    ref_idx_t cur_col;
    score_t   h_diag;
    score_t   e_new;
    score_t   f_new;
    score_t   h_new;
    logic     update;

    function automatic score_t max2(input score_t a, input score_t b);
        return (a > b) ? a : b;
    endfunction

    // element 0 processes base 0 in the start cycle itself
    assign left_h   = i_start ? '0 : o_h;
    assign left_e   = i_start ? '0 : e_q;
    assign diag     = i_start ? '0 : diag_q;
    assign cur_best = i_start ? '0 : o_row_best;
    assign cur_col  = i_start ? '0 : col_q;

    assign h_diag = (i_ref_base == i_read_base) ? diag + MATCH_SCORE : diag - MISMATCH_PENALTY;
    assign e_new  = max2(max2(left_e - GAP_EXTEND, left_h - GAP_OPEN), '0);
    assign f_new  = max2(max2(i_top_f - GAP_EXTEND, i_top_h - GAP_OPEN), '0);
    assign h_new  = max2(max2(e_new, f_new), max2(h_diag, '0));

    assign update = i_valid && i_row_en;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_ref_base <= i_ref_base;
        // top h one column back becomes the diagonal
        diag_q     <= i_start ? '0 : i_top_h;
        if (i_start) begin
            o_h            <= '0;
            e_q            <= '0;
            o_f            <= '0;
            col_q          <= '0;
            o_row_best     <= '0;
            o_row_best_col <= '0;
        end
        if (update) begin
            o_h   <= h_new;
            e_q   <= e_new;
            o_f   <= f_new;
            col_q <= cur_col + 1'b1;
            // strict compare keeps the earliest column
            if (h_new > cur_best) begin
                o_row_best     <= h_new;
                o_row_best_col <= cur_col;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/sw_pe_array.sv */
// chain of READ_MAX_LEN processing elements, one per read base, with a row-best read port for the scan
`timescale 1ns/1ps
`default_nettype none

module sw_pe_array (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_start,
    input  logic              i_stream_valid,
    input  sw_pkg::base_t     i_stream_base,
    input  sw_pkg::read_seq_t i_read_seq,
    input  sw_pkg::read_len_t i_read_len,
    input  sw_pkg::read_idx_t i_row_sel,
    output sw_pkg::score_t    o_row_best,
    output sw_pkg::ref_idx_t  o_row_best_col
);
    import sw_pkg::*;

    // entry j feeds element j, entry 0 is the array input
    logic     valid_link   [0:READ_MAX_LEN];
    base_t    base_link    [0:READ_MAX_LEN];
    score_t   h_link       [0:READ_MAX_LEN];
    score_t   f_link       [0:READ_MAX_LEN];
    score_t   row_best     [0:READ_MAX_LEN-1];
    ref_idx_t row_best_col [0:READ_MAX_LEN-1];
    logic [READ_MAX_LEN-1:0] row_en;

    assign valid_link[0] = i_stream_valid;
    assign base_link[0]  = i_stream_base;

    // top boundary of row 0
    assign h_link[0] = '0;
    assign f_link[0] = '0;

    generate
        for (genvar j = 0; j < READ_MAX_LEN; j++) begin : g_pe
            // rows past the read length stay idle
            assign row_en[j] = (read_len_t'(j) < i_read_len);

            sw_pe pe_inst (
                .clk            (clk),
                .rst            (rst),
                .i_start        (i_start),
                .i_row_en       (row_en[j]),
                .i_valid        (valid_link[j]),
                .i_ref_base     (base_link[j]),
                .i_read_base    (i_read_seq[2*j +: 2]),
                .i_top_h        (h_link[j]),
                .i_top_f        (f_link[j]),
                .o_valid        (valid_link[j+1]),
                .o_ref_base     (base_link[j+1]),
                .o_h            (h_link[j+1]),
                .o_f            (f_link[j+1]),
                .o_row_best     (row_best[j]),
                .o_row_best_col (row_best_col[j])
            );
        end
    endgenerate

    // row read port for the selector
    assign o_row_best     = row_best[i_row_sel];
    assign o_row_best_col = row_best_col[i_row_sel];

endmodule

`default_nettype wire

/* logic/sw_max_select.sv */
// scans the row bests of the array for the global best and holds it on the output handshake
`timescale 1ns/1ps
`default_nettype none

module sw_max_select (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_scan_start,
    input  sw_pkg::read_len_t i_read_len,
    input  sw_pkg::score_t    i_row_best,
    input  sw_pkg::ref_idx_t  i_row_best_col,
    input  logic              i_ready,
    output sw_pkg::read_idx_t o_row_sel,
    output logic              o_scan_busy,
    output logic              o_valid,
    output sw_pkg::score_t    o_score,
    output sw_pkg::read_idx_t o_row,
    output sw_pkg::ref_idx_t  o_column
);
    import sw_pkg::*;

    logic scanning;
    logic last_row;
    logic take;

    // also stops at the last element if the length is out of range
    assign last_row = (read_len_t'(o_row_sel) == i_read_len - read_len_t'(1))
                   || (o_row_sel == read_idx_t'(READ_MAX_LEN - 1));

    // row 0 seeds the best, later rows only win when strictly higher
    assign take = (o_row_sel == '0) || (i_row_best > o_score);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scanning    <= 1'b0;
            o_scan_busy <= 1'b0;
            o_valid     <= 1'b0;
            o_row_sel   <= '0;
        end else begin
            if (i_scan_start) begin
                scanning    <= 1'b1;
                o_scan_busy <= 1'b1;
                o_row_sel   <= '0;
            end else if (scanning) begin
                if (last_row) begin
                    scanning <= 1'b0;
                    o_valid  <= 1'b1;
                end else begin
                    o_row_sel <= o_row_sel + 1'b1;
                end
            end
            // busy holds the loader until the result is taken
            if (o_valid && i_ready) begin
                o_valid     <= 1'b0;
                o_scan_busy <= 1'b0;
            end
        end
    end

    // result only moves during the scan, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (scanning && take) begin
            o_score  <= i_row_best;
            o_row    <= o_row_sel;
            o_column <= i_row_best_col;
        end
    end

endmodule

`default_nettype wire

/* logic/sw_core.sv */
// top level of the smith-waterman engine, loader into pe array into row-best selector
`timescale 1ns/1ps
`default_nettype none

module sw_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_valid,
    input  sw_pkg::ref_seq_t  i_ref_seq,
    input  sw_pkg::read_seq_t i_read_seq,
    input  sw_pkg::ref_len_t  i_ref_len,
    input  sw_pkg::read_len_t i_read_len,
    input  logic              i_ready,
    output logic              o_ready,
    output logic              o_valid,
    output sw_pkg::score_t    o_score,
    output sw_pkg::read_idx_t o_row,
    output sw_pkg::ref_idx_t  o_column
);
    import sw_pkg::*;

    logic      start;
    logic      stream_valid;
    base_t     stream_base;
    read_seq_t read_seq;
    read_len_t read_len;
    logic      scan_start;
    logic      scan_busy;
    read_idx_t row_sel;
    score_t    row_best;
    ref_idx_t  row_best_col;

    sw_seq_loader loader_inst (
        .clk            (clk),
        .rst            (rst),
        .i_valid        (i_valid),
        .i_ref_seq      (i_ref_seq),
        .i_read_seq     (i_read_seq),
        .i_ref_len      (i_ref_len),
        .i_read_len     (i_read_len),
        .i_scan_busy    (scan_busy),
        .o_ready        (o_ready),
        .o_start        (start),
        .o_stream_valid (stream_valid),
        .o_stream_base  (stream_base),
        .o_read_seq     (read_seq),
        .o_read_len     (read_len),
        .o_scan_start   (scan_start)
    );

    sw_pe_array array_inst (
        .clk            (clk),
        .rst            (rst),
        .i_start        (start),
        .i_stream_valid (stream_valid),
        .i_stream_base  (stream_base),
        .i_read_seq     (read_seq),
        .i_read_len     (read_len),
        .i_row_sel      (row_sel),
        .o_row_best     (row_best),
        .o_row_best_col (row_best_col)
    );

    sw_max_select select_inst (
        .clk            (clk),
        .rst            (rst),
        .i_scan_start   (scan_start),
        .i_read_len     (read_len),
        .i_row_best     (row_best),
        .i_row_best_col (row_best_col),
        .i_ready        (i_ready),
        .o_row_sel      (row_sel),
        .o_scan_busy    (scan_busy),
        .o_valid        (o_valid),
        .o_score        (o_score),
        .o_row          (o_row),
        .o_column       (o_column)
    );

endmodule

`default_nettype wire

/* verification/sw_ref_model.svh */
// scoring model of the smith-waterman engine, included inside the testbench module after the package import
`ifndef SW_REF_MODEL_SVH
`define SW_REF_MODEL_SVH

function automatic int max_of(input int a, input int b);
    return (a > b) ? a : b;
endfunction

// full matrix fill, row-major scan with strict compare gives the tie order
function automatic void best_local_alignment(
    input  ref_seq_t  ref_seq,
    input  read_seq_t read_seq,
    input  int        ref_len,
    input  int        read_len,
    output int        best_score,
    output int        best_row,
    output int        best_col
);
    int         h [0:READ_MAX_LEN][0:REF_MAX_LEN];
    int         e [0:READ_MAX_LEN][0:REF_MAX_LEN];
    int         f [0:READ_MAX_LEN][0:REF_MAX_LEN];
    int         diag_val;
    logic [1:0] ref_base;
    logic [1:0] read_base;

    // boundary row and column stay zero
    for (int r = 0; r <= READ_MAX_LEN; r++) begin
        for (int c = 0; c <= REF_MAX_LEN; c++) begin
            h[r][c] = 0;
            e[r][c] = 0;
            f[r][c] = 0;
        end
    end

    best_score = 0;
    best_row   = 0;
    best_col   = 0;

    for (int r = 1; r <= read_len; r++) begin
        for (int c = 1; c <= ref_len; c++) begin
            ref_base  = ref_seq[2*(c-1) +: 2];
            read_base = read_seq[2*(r-1) +: 2];
            if (ref_base == read_base) begin
                diag_val = h[r-1][c-1] + int'(MATCH_SCORE);
            end else begin
                diag_val = h[r-1][c-1] - int'(MISMATCH_PENALTY);
            end
            e[r][c] = max_of(0, max_of(e[r][c-1] - int'(GAP_EXTEND),
                                       h[r][c-1] - int'(GAP_OPEN)));
            f[r][c] = max_of(0, max_of(f[r-1][c] - int'(GAP_EXTEND),
                                       h[r-1][c] - int'(GAP_OPEN)));
            h[r][c] = max_of(max_of(0, diag_val), max_of(e[r][c], f[r][c]));
            if (h[r][c] > best_score) begin
                best_score = h[r][c];
                best_row   = r - 1;
                best_col   = c - 1;
            end
        end
    end
endfunction

`endif

/* verification/sw_core_tb.sv */
// testbench for the smith-waterman core, directed and random jobs checked against a scoring model
`timescale 1ns/1ps
`default_nettype none

module sw_core_tb;
    import sw_pkg::*;

    localparam int          CLK_PERIOD_NS = 4;
    localparam int          RESET_CYCLES  = 4;
    localparam int          PREFIX_JOBS   = 4;
    localparam int          RANDOM_JOBS   = 40;
    localparam int          EXTREME_JOBS  = 3;
    localparam int          JOB_COUNT     = PREFIX_JOBS + RANDOM_JOBS + EXTREME_JOBS;
    localparam int          WATCHDOG_NS   = JOB_COUNT * 64 * CLK_PERIOD_NS;
    localparam int          MAX_HOLD      = 10;
    localparam logic [31:0] SEED          = 32'h468bfefc;

    logic      clk;
    logic      rst;
    logic      i_valid;
    ref_seq_t  i_ref_seq;
    read_seq_t i_read_seq;
    ref_len_t  i_ref_len;
    read_len_t i_read_len;
    logic      i_ready;
    logic      o_ready;
    logic      o_valid;
    score_t    o_score;
    read_idx_t o_row;
    ref_idx_t  o_column;

    // expected results in job order
    int exp_score_q [$];
    int exp_row_q   [$];
    int exp_col_q   [$];
    int results_seen;

    // snapshot of a result waiting under back-pressure
    logic      held_valid;
    score_t    held_score;
    read_idx_t held_row;
    ref_idx_t  held_col;

    `include "sw_ref_model.svh"

    sw_core sw_core_inst (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_valid),
        .i_ref_seq  (i_ref_seq),
        .i_read_seq (i_read_seq),
        .i_ref_len  (i_ref_len),
        .i_read_len (i_read_len),
        .i_ready    (i_ready),
        .o_ready    (o_ready),
        .o_valid    (o_valid),
        .o_score    (o_score),
        .o_row      (o_row),
        .o_column   (o_column)
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s, expected %0d, got %0d",
                                        $time, what, expected, actual));
        end
    endtask

    // one job through both handshakes, result held back for hold cycles
    task automatic send_job(input ref_seq_t rs, input read_seq_t qs, input int rl,
                            input int ql, input int want_score, input int want_row,
                            input int want_col, input int hold);
        exp_score_q.push_back(want_score);
        exp_row_q.push_back(want_row);
        exp_col_q.push_back(want_col);
        @(posedge clk);
        i_valid    <= 1'b1;
        i_ref_seq  <= rs;
        i_read_seq <= qs;
        i_ref_len  <= ref_len_t'(rl);
        i_read_len <= read_len_t'(ql);
        do @(negedge clk); while (!o_ready);
        @(posedge clk);
        i_valid <= 1'b0;
        do @(negedge clk); while (!o_valid);
        repeat (hold) @(negedge clk);
        @(posedge clk);
        i_ready <= 1'b1;
        @(posedge clk);
        i_ready <= 1'b0;
    endtask

    task automatic run_modeled_job(input ref_seq_t rs, input read_seq_t qs, input int rl,
                                   input int ql);
        int score;
        int row;
        int col;
        best_local_alignment(rs, qs, rl, ql, score, row, col);
        send_job(rs, qs, rl, ql, score, row, col, $urandom_range(MAX_HOLD, 0));
    endtask

    initial begin
        ref_seq_t  rs;
        read_seq_t qs;
        int        rl;
        int        ql;

        clk          = 1'b0;
        rst          = 1'b1;
        i_valid      = 1'b0;
        i_ref_seq    = '0;
        i_read_seq   = '0;
        i_ref_len    = '0;
        i_read_len   = '0;
        i_ready      = 1'b0;
        results_seen = 0;
        held_valid   = 1'b0;
        void'($urandom(SEED));

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value(int'(o_valid), 0, "o_valid after reset");
        check_value(int'(o_ready), 1, "o_ready after reset");

        // read is a prefix of the reference, full match on the diagonal
        for (int k = 0; k < PREFIX_JOBS; k++) begin
            rs = $urandom;
            qs = rs[2*READ_MAX_LEN-1:0];
            ql = 2 * k + 2;
            rl = $urandom_range(REF_MAX_LEN, ql);
            send_job(rs, qs, rl, ql, int'(MATCH_SCORE) * ql, ql - 1, ql - 1,
                     $urandom_range(MAX_HOLD, 0));
        end

        for (int k = 0; k < RANDOM_JOBS; k++) begin
            rs = $urandom;
            qs = read_seq_t'($urandom);
            rl = $urandom_range(REF_MAX_LEN, 1);
            ql = $urandom_range(READ_MAX_LEN, 1);
            run_modeled_job(rs, qs, rl, ql);
        end

        // shortest and longest jobs
        run_modeled_job(ref_seq_t'($urandom), read_seq_t'($urandom), 1, 1);
        run_modeled_job(ref_seq_t'($urandom), read_seq_t'($urandom), REF_MAX_LEN, READ_MAX_LEN);
        // all A against all C
        send_job('0, {READ_MAX_LEN{2'b01}}, REF_MAX_LEN, READ_MAX_LEN, 0, 0, 0,
                 $urandom_range(MAX_HOLD, 0));

        // engine back to idle once the last result is gone
        repeat (2) @(negedge clk);
        check_value(int'(o_valid), 0, "o_valid after the last result");
        check_value(int'(o_ready), 1, "o_ready after the last result");
        $display("TESTS PASSED");
        $finish;
    end

    // outputs are sampled on the falling edge, away from the driving edge
    always @(negedge clk) begin
        if (!rst) begin
            if (held_valid && !o_valid) begin
                stop_with_failure("o_valid dropped before the result was consumed");
            end
            if (o_valid) begin
                check_value(int'(o_ready), 0, "o_ready while a result waits");
            end
            if (o_valid && held_valid) begin
                check_value(int'(o_score), int'(held_score), "o_score under back-pressure");
                check_value(int'(o_row), int'(held_row), "o_row under back-pressure");
                check_value(int'(o_column), int'(held_col), "o_column under back-pressure");
            end
            if (o_valid && i_ready) begin
                if (exp_score_q.size() == 0) begin
                    stop_with_failure("a result was consumed with no job pending");
                end
                check_value(int'(o_score), exp_score_q.pop_front(), "score");
                check_value(int'(o_row), exp_row_q.pop_front(), "row");
                check_value(int'(o_column), exp_col_q.pop_front(), "column");
                results_seen++;
                held_valid = 1'b0;
            end else begin
                held_valid = o_valid;
                held_score = o_score;
                held_row   = o_row;
                held_col   = o_column;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure($sformatf("timeout after %0d ns with %0d of %0d results consumed",
                                    WATCHDOG_NS, results_seen, JOB_COUNT));
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+verification
logic/sw_pkg.sv
logic/sw_seq_loader.sv
logic/sw_pe.sv
logic/sw_pe_array.sv
logic/sw_max_select.sv
logic/sw_core.sv
verification/sw_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the Smith-Waterman testbench with Verilator and run it.
# The exit status is the simulator's status.

set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=sw_core_sim

verilator --binary --timing -j 0 \
    --timescale 1ns/1ps \
    --top-module sw_core_tb \
    --Mdir "${OBJ_DIR}" \
    -o "${SIM_BIN}" \
    -f build.f
status=$?
if [ ${status} -ne 0 ]; then
    echo "verilator build failed with status ${status}"
    exit ${status}
fi

"./${OBJ_DIR}/${SIM_BIN}"
status=$?
if [ ${status} -ne 0 ]; then
    echo "simulation failed with status ${status}"
    exit ${status}
fi

exit 0
